// File: hdl/dual_port_sram.sv
`include "sram_test_defines.svh"

module dual_port_sram
   import sram_test_pkg::*;
(
   input  logic       clk,
   input  sram_port_t port0_req,
   input  sram_port_t port1_req,
   // Decoded chip selects take the place of the request csb fields
   input  logic       csb0,
   input  logic       csb1,
   output sram_read_t rdata
);

   localparam int DEPTH  = 2 ** `ADDR_SIZE;
   localparam int NIBBLE = `DATA_SIZE / `WMASK_SIZE;

   logic [`DATA_SIZE-1:0] mem [DEPTH];

   logic write0;
   logic write1;
   logic read0;
   logic read1;

   // Merge the enabled nibbles of the new data into the old word
   function automatic logic [`DATA_SIZE-1:0] masked_word(
      input logic [`DATA_SIZE-1:0]  old_word,
      input logic [`DATA_SIZE-1:0]  new_word,
      input logic [`WMASK_SIZE-1:0] mask
   );
      logic [`DATA_SIZE-1:0] result;
      result = old_word;
      for (int i = 0; i < `WMASK_SIZE; i++) begin
         if (mask[i]) begin
            result[i*NIBBLE +: NIBBLE] = new_word[i*NIBBLE +: NIBBLE];
         end
      end
      return result;
   endfunction

   assign write0 = !csb0 && !port0_req.web;
   assign write1 = !csb1 && !port1_req.web;
   assign read0  = !csb0 && port0_req.web;
   assign read1  = !csb1 && port1_req.web;

   // Port1 is applied last, so it wins a same-address collision
   always_ff @(posedge clk) begin
      if (write0) begin
         mem[port0_req.addr] <= masked_word(mem[port0_req.addr], port0_req.din,
                                            port0_req.wmask);
      end
      if (write1) begin
         mem[port1_req.addr] <= masked_word(mem[port1_req.addr], port1_req.din,
                                            port1_req.wmask);
      end
   end

   // Registered reads hold their output while the port is idle or writing
   always_ff @(posedge clk) begin
      if (read0) begin
         rdata.data0 <= mem[port0_req.addr];
      end
      if (read1) begin
         rdata.data1 <= mem[port1_req.addr];
      end
   end

endmodule

// File: hdl/port_decode.sv
`include "sram_test_defines.svh"

module port_decode
   import sram_test_pkg::*;
(
   input  sram_instr_t           instr,
   // Requests shared by all macros
   output sram_port_t            port0,
   output sram_port_t            port1,
   // Per-macro active-low selects with one bit per chip
   output logic [`MAX_CHIPS-1:0] csb0,
   output logic [`MAX_CHIPS-1:0] csb1
);

   // Address, data, web and mask go to every macro unchanged
   always_comb begin
      port0 = instr.port0;
      port1 = instr.port1;
   end

   // Only the addressed chip sees the port's csb
   // Every other chip stays deselected
   always_comb begin
      csb0 = '1;
      csb1 = '1;
      csb0[instr.chip_select] = instr.port0.csb;
      csb1[instr.chip_select] = instr.port1.csb;
   end

endmodule

// File: hdl/scan_instr_reg.sv
`include "sram_test_defines.svh"

module scan_instr_reg
   import sram_test_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   // Shift has highest priority and capture lowest
   input  logic        shift_en,
   input  logic        load_en,
   input  logic        capture_en,
   // Serial data enters at the least significant bit
   input  logic        scan_in,
   // Parallel word for a load
   input  sram_instr_t load_data,
   // Read words from every macro in the bank
   input  sram_read_t  read_data [`MAX_CHIPS],
   output sram_instr_t instr,
   output logic        scan_out
);

   // Read words of the chip that the instruction addresses
   sram_read_t selected;

   // Shifted version of the current word
   logic [`TOTAL_SIZE-1:0] shifted;

   // Pick the macro named by the stored chip select
   always_comb begin
      selected = read_data[instr.chip_select];
   end

   // Drop the top bit and take the next serial bit in at the bottom
   assign shifted = {instr[`TOTAL_SIZE-2:0], scan_in};

   always_ff @(posedge clk) begin
      if (reset) begin
         instr <= '0;
      end else if (shift_en) begin
         instr <= sram_instr_t'(shifted);
      end else if (load_en) begin
         instr <= load_data;
      end else if (capture_en) begin
         // Only the data fields are replaced
         // Address, controls and masks stay as loaded
         instr.port0.din <= selected.data0;
         instr.port1.din <= selected.data1;
      end
   end

   // Most significant bit leaves first on a shift
   assign scan_out = instr[`TOTAL_SIZE-1];

endmodule

// File: hdl/sram_bank.sv
`include "sram_test_defines.svh"

module sram_bank
   import sram_test_pkg::*;
(
   input  logic                  clk,
   // Shared requests from the decoder
   input  sram_port_t            port0,
   input  sram_port_t            port1,
   // One select bit per macro and port
   input  logic [`MAX_CHIPS-1:0] csb0,
   input  logic [`MAX_CHIPS-1:0] csb1,
   // Read words of every macro indexed by chip number
   output sram_read_t            read_data [`MAX_CHIPS]
);

   // Every macro sees the same request
   // Its own csb bits decide whether it acts on it
   for (genvar chip = 0; chip < `MAX_CHIPS; chip++) begin : g_macro
      dual_port_sram i_sram (
         .clk       (clk),
         .port0_req (port0),
         .port1_req (port1),
         .csb0      (csb0[chip]),
         .csb1      (csb1[chip]),
         .rdata     (read_data[chip])
      );
   end

endmodule

// File: hdl/sram_test_chip.sv
`include "sram_test_defines.svh"

module sram_test_chip
   import sram_test_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   // High selects the GPIO pins and low the LA pins
   input  logic                   in_select,
   // GPIO control
   input  logic                   gpio_in,
   input  logic                   gpio_scan,
   input  logic                   gpio_sram_load,
   // LA control
   input  logic                   la_in_load,
   input  logic                   la_sram_load,
   input  logic [`TOTAL_SIZE-1:0] la_data_in,
   output logic [`TOTAL_SIZE-1:0] la_data_out,
   output logic                   gpio_out
);

   logic shift_en;
   logic load_en;
   logic capture_en;

   sram_instr_t load_word;
   sram_instr_t instr;

   sram_port_t port0;
   sram_port_t port1;

   logic [`MAX_CHIPS-1:0] csb0;
   logic [`MAX_CHIPS-1:0] csb1;

   sram_read_t read_data [`MAX_CHIPS];

   // Only the pin set picked by in_select is obeyed
   // Scan comes only from GPIO and parallel load only from LA
   assign shift_en   = in_select && gpio_scan;
   assign load_en    = !in_select && la_in_load;
   assign capture_en = in_select ? gpio_sram_load : la_sram_load;

   assign load_word = sram_instr_t'(la_data_in);

   scan_instr_reg i_instr_reg (
      .clk        (clk),
      .reset      (reset),
      .shift_en   (shift_en),
      .load_en    (load_en),
      .capture_en (capture_en),
      .scan_in    (gpio_in),
      .load_data  (load_word),
      .read_data  (read_data),
      .instr      (instr),
      .scan_out   (gpio_out)
   );

   port_decode i_port_decode (
      .instr (instr),
      .port0 (port0),
      .port1 (port1),
      .csb0  (csb0),
      .csb1  (csb1)
   );

   sram_bank i_sram_bank (
      .clk       (clk),
      .port0     (port0),
      .port1     (port1),
      .csb0      (csb0),
      .csb1      (csb1),
      .read_data (read_data)
   );

   // Host sees the whole instruction word in parallel
   assign la_data_out = instr;

endmodule

// File: hdl/sram_test_defines.svh
`ifndef SRAM_TEST_DEFINES_SVH
`define SRAM_TEST_DEFINES_SVH

// Word address width for sixteen words per macro
`define ADDR_SIZE 4

// Data word width
`define DATA_SIZE 8

// One mask bit per 4-bit nibble of the data word
`define WMASK_SIZE 2

// Number of SRAM macros on the chip
`define MAX_CHIPS 4

// Width of the chip index in the instruction word
`define SELECT_SIZE 2

// One port request holds addr, din, csb, web and wmask
`define PORT_SIZE (`ADDR_SIZE + `DATA_SIZE + 2 + `WMASK_SIZE)

// Full instruction word with chip select plus two port requests
`define TOTAL_SIZE (`SELECT_SIZE + 2 * `PORT_SIZE)

`endif

// File: hdl/sram_test_pkg.sv
`include "sram_test_defines.svh"

package sram_test_pkg;

   // Request for one port of a macro with the most significant field first
   typedef struct packed {
      logic [`ADDR_SIZE-1:0]  addr;
      logic [`DATA_SIZE-1:0]  din;
      // Active-low chip select
      logic                   csb;
      // Active-low write enable
      logic                   web;
      logic [`WMASK_SIZE-1:0] wmask;
   } sram_port_t;

   // Instruction word as held in the scan register
   // Chip select sits on top and port1 occupies the low bits
   typedef struct packed {
      logic [`SELECT_SIZE-1:0] chip_select;
      sram_port_t              port0;
      sram_port_t              port1;
   } sram_instr_t;

   // Registered read words of one macro
   typedef struct packed {
      logic [`DATA_SIZE-1:0] data0;
      logic [`DATA_SIZE-1:0] data1;
   } sram_read_t;

endpackage

// File: sram_test_chip.f
+incdir+hdl
hdl/sram_test_pkg.sv
hdl/scan_instr_reg.sv
hdl/port_decode.sv
hdl/dual_port_sram.sv
hdl/sram_bank.sv
hdl/sram_test_chip.sv
tb/sram_test_chip_tb.sv

// File: tb/sram_test_chip_tb.sv
`include "sram_test_defines.svh"

module sram_test_chip_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int TIMEOUT_CYCLES = 5000;
   localparam int MAX_LINES      = 500;

   logic                   clk;
   logic                   reset;
   logic                   in_select;
   logic                   gpio_in;
   logic                   gpio_scan;
   logic                   gpio_sram_load;
   logic                   la_in_load;
   logic                   la_sram_load;
   logic [`TOTAL_SIZE-1:0] la_data_in;
   logic [`TOTAL_SIZE-1:0] la_data_out;
   logic                   gpio_out;

   logic [31:0] lfsr;
   int          checks;

   sram_test_chip i_dut (
      .clk            (clk),
      .reset          (reset),
      .in_select      (in_select),
      .gpio_in        (gpio_in),
      .gpio_scan      (gpio_scan),
      .gpio_sram_load (gpio_sram_load),
      .la_in_load     (la_in_load),
      .la_sram_load   (la_sram_load),
      .la_data_in     (la_data_in),
      .la_data_out    (la_data_out),
      .gpio_out       (gpio_out)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #5 clk = ~clk;
      end
   end

   // Fibonacci LFSR with taps 32, 22, 2 and 1
   function automatic logic [31:0] next_lfsr(input logic [31:0] state);
      logic feedback;
      feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
      return {state[30:0], feedback};
   endfunction

   task automatic stop_run();
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [`TOTAL_SIZE-1:0] actual,
                              input logic [`TOTAL_SIZE-1:0] expected);
      checks++;
      if (actual !== expected) begin
         $display("Fail: %s is %h, expected %h", name, actual, expected);
         stop_run();
      end
   endtask

   // Zero to three idle cycles drawn from two LFSR bits
   task automatic idle_gap();
      int cycles;
      cycles = 0;
      repeat (2) begin
         lfsr = next_lfsr(lfsr);
         cycles = cycles * 2 + lfsr[0];
      end
      repeat (cycles) @(posedge clk);
   endtask

   // LA load that the DUT obeys only when in_select is low
   task automatic parallel_load(input logic [`TOTAL_SIZE-1:0] word, input logic gpio_side);
      @(posedge clk);
      in_select  <= gpio_side;
      la_data_in <= word;
      la_in_load <= 1'b1;
      @(posedge clk);
      la_in_load <= 1'b0;
   endtask

   // Most significant bit enters first
   task automatic scan_in_word(input logic [`TOTAL_SIZE-1:0] word);
      @(posedge clk);
      in_select <= 1'b1;
      gpio_scan <= 1'b1;
      gpio_in   <= word[`TOTAL_SIZE-1];
      for (int i = `TOTAL_SIZE - 2; i >= 0; i--) begin
         @(posedge clk);
         gpio_in <= word[i];
      end
      @(posedge clk);
      gpio_scan <= 1'b0;
      gpio_in   <= 1'b0;
   endtask

   task automatic capture_read(input logic gpio_side);
      @(posedge clk);
      in_select <= gpio_side;
      if (gpio_side) begin
         gpio_sram_load <= 1'b1;
      end else begin
         la_sram_load <= 1'b1;
      end
      @(posedge clk);
      gpio_sram_load <= 1'b0;
      la_sram_load   <= 1'b0;
   endtask

   // gpio_out always carries the top bit of the word
   task automatic expect_word(input logic [`TOTAL_SIZE-1:0] word);
      @(negedge clk);
      check_value("la_data_out", la_data_out, word);
      check_value("gpio_out", gpio_out, word[`TOTAL_SIZE-1]);
   endtask

   // Zeros are shifted in while the word leaves on gpio_out
   task automatic shift_out_word(input logic [`TOTAL_SIZE-1:0] word);
      @(posedge clk);
      in_select <= 1'b1;
      gpio_scan <= 1'b1;
      gpio_in   <= 1'b0;
      for (int i = `TOTAL_SIZE - 1; i >= 0; i--) begin
         @(negedge clk);
         check_value("gpio_out", gpio_out, word[i]);
         @(posedge clk);
      end
      gpio_scan <= 1'b0;
   endtask

   // Watchdog for the whole run
   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
      stop_run();
   end

   initial begin
      int                     fd;
      int                     line_no;
      int                     fields;
      string                  line;
      string                  cmd;
      logic [`TOTAL_SIZE-1:0] operand;

      reset          = 1'b1;
      in_select      = 1'b0;
      gpio_in        = 1'b0;
      gpio_scan      = 1'b0;
      gpio_sram_load = 1'b0;
      la_in_load     = 1'b0;
      la_sram_load   = 1'b0;
      la_data_in     = '0;
      lfsr           = 32'h1af;
      checks         = 0;
      line_no        = 0;

      repeat (2) @(posedge clk);
      reset <= 1'b0;

      fd = $fopen("tb/sram_test_testdata.txt", "r");
      if (fd == 0) begin
         $display("Could not open the test data file tb/sram_test_testdata.txt");
         stop_run();
      end

      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         line_no++;
         if (line_no > MAX_LINES) begin
            $display("Test data file is longer than %0d lines", MAX_LINES);
            stop_run();
         end
         // Skip blank and comment lines
         if (line.len() < 2 || line.substr(0, 1) == "//") begin
            continue;
         end
         fields = $sscanf(line, "%s %h", cmd, operand);
         if (fields != 2) begin
            $display("Test data line %0d is not a command and an operand", line_no);
            stop_run();
         end
         case (cmd)
            "L": begin
               parallel_load(operand, 1'b0);
               idle_gap();
            end
            "X": begin
               parallel_load(operand, 1'b1);
               idle_gap();
            end
            "G": begin
               scan_in_word(operand);
               idle_gap();
            end
            "C": begin
               capture_read(operand[0]);
               idle_gap();
            end
            "E": expect_word(operand);
            "O": shift_out_word(operand);
            default: begin
               $display("Test data line %0d has an unknown command %s", line_no, cmd);
               stop_run();
            end
         endcase
      end
      $fclose(fd);

      if (checks == 0) begin
         $display("No checks were found in the test data file");
         stop_run();
      end else begin
         $display("PASS: all tests");
      end
      $finish;
   end

endmodule

// File: tb/sram_test_testdata.txt
// Columns: command letter, hex operand (34-bit word, or 0/1 flag for C)
// L load over LA, G scan in over GPIO, C capture (1 = GPIO pins, 0 = LA pins)
// X LA load with in_select high, E expected la_data_out, O expected bits on gpio_out
E 000000000
L 3A5C9F0B6
E 3A5C9F0B6
// Chip 1 writes addr 3 and 7, then reads them back
L 135A37C33
E 135A37C33
L 13FF47006
C 0
E 135A47C36
// Chip 2 full writes, then nibble-masked writes
L 293C34663
L 29A5241F1
L 290044004
C 1
E 29AC446F4
// Chip 0 at the same address must not disturb chip 2
L 09113000C
L 290044004
C 0
E 29AC446F4
L 090049004
C 1
E 091149114
// Both ports write one address, port1 wins
L 321232343
L 320042004
C 0
E 323442344
// LA load ignored while GPIO pins are selected
X 1FFFFFFFF
E 323442344
// Serial scan in, then shift out
G 2DEADBEEF
E 2DEADBEEF
O 2DEADBEEF
E 000000000
